//--- Bender.yml
package:
  name: soc_mem

sources:
  - design/bus_pkg.sv
  - design/soc_map_pkg.sv
  - design/mem_arbiter.sv
  - design/mem_router.sv
  - design/clint_timer.sv
  - design/soc_mem_top.sv
  - target: test
    files:
      - test/tb_soc_mem_chk.sv
      - test/tb_soc_mem.sv

//--- design/bus_pkg.sv
`default_nettype none

package bus_pkg;

  localparam int addr_width = 32;
  localparam int data_width = 32;
  localparam int strb_width = data_width / 8;
  localparam int id_width   = 4;

  typedef enum logic [1:0] {
    resp_okay   = 2'b00,
    resp_exokay = 2'b01,
    resp_slverr = 2'b10,
    resp_decerr = 2'b11
  } resp_e;

  typedef enum logic [1:0] {
    grant_none,
    grant_fetch,
    grant_lsu
  } grant_e;

  typedef enum logic [1:0] {
    target_none,
    target_timer,
    target_ext
  } target_e;

  typedef enum logic {
    arb_idle,
    arb_busy
  } arb_state_e;

endpackage

`default_nettype wire

//--- design/clint_timer.sv
`timescale 1ns/1ps
`default_nettype none

module clint_timer import bus_pkg::*, soc_map_pkg::*; #(
  parameter logic [addr_width-1:0] mtime_addr = default_mtime_addr
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [addr_width-1:0] araddr,
  input  logic                  arvalid,
  output logic                  arready,
  input  logic                  rready,
  output logic [data_width-1:0] rdata,
  output resp_e                 rresp,
  output logic                  rvalid
);

  logic [63:0]           mtime;
  logic [data_width-1:0] rdata_q;
  logic                  hi_word;

  // bit 2 picks the half relative to the low word.
  assign hi_word = araddr[2] ^ mtime_addr[2];

  assign arready = ~rvalid;
  assign rdata   = rdata_q;
  assign rresp   = resp_okay;

  always_ff @(posedge clock) begin
    if (reset) begin
      mtime <= '0;
    end else begin
      mtime <= mtime + 64'd1;
    end
  end

  always_ff @(posedge clock) begin
    if (reset) begin
      rvalid <= 1'b0;
    end else if (arvalid & arready) begin
      rvalid <= 1'b1;
    end else if (rready) begin
      rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clock) begin
    if (arvalid & arready) begin
      rdata_q <= hi_word ? mtime[63:32] : mtime[31:0]; // value before this edge.
    end
  end

endmodule

`default_nettype wire

//--- design/mem_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter import bus_pkg::*, soc_map_pkg::*; #(
  parameter logic [addr_width-1:0] mtime_addr = default_mtime_addr
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  arvalid_0,
  input  logic [addr_width-1:0] araddr_0,
  input  logic                  arvalid_1,
  input  logic [addr_width-1:0] araddr_1,
  input  logic                  awvalid_1,
  input  logic                  txn_done,
  output grant_e                grant,
  output target_e               target
);

  arb_state_e state;

  function automatic target_e decode_read(input logic [addr_width-1:0] addr);
    logic hit;
    hit = (addr == mtime_addr) || (addr == mtime_addr + addr_width'(4));
    return hit ? target_timer : target_ext;
  endfunction

  always_ff @(posedge clock) begin
    if (reset) begin
      state  <= arb_idle;
      grant  <= grant_none;
      target <= target_none;
    end else begin
      case (state)
        arb_idle: begin
          if (arvalid_0) begin
            state  <= arb_busy;
            grant  <= grant_fetch;
            target <= decode_read(araddr_0);
          end else if (arvalid_1) begin // lsu read wins over lsu write.
            state  <= arb_busy;
            grant  <= grant_lsu;
            target <= decode_read(araddr_1);
          end else if (awvalid_1) begin
            state  <= arb_busy;
            grant  <= grant_lsu;
            target <= target_ext; // timer is read-only.
          end
        end
        arb_busy: begin
          if (txn_done) begin
            state  <= arb_idle;
            grant  <= grant_none;
            target <= target_none;
          end
        end
        default: begin
          state  <= arb_idle;
          grant  <= grant_none;
          target <= target_none;
        end
      endcase
    end
  end

endmodule

`default_nettype wire

//--- design/mem_router.sv
`timescale 1ns/1ps
`default_nettype none

module mem_router import bus_pkg::*, soc_map_pkg::*; #(
  parameter logic [id_width-1:0] ext_id = default_ext_id
) (
  input  logic                  clock,
  input  logic                  reset,
  input  grant_e                grant,
  input  target_e               target,
  input  logic [addr_width-1:0] araddr_0,
  input  logic                  arvalid_0,
  output logic                  arready_0,
  input  logic                  rready_0,
  output logic [data_width-1:0] rdata_0,
  output resp_e                 rresp_0,
  output logic                  rvalid_0,
  input  logic [addr_width-1:0] araddr_1,
  input  logic                  arvalid_1,
  output logic                  arready_1,
  input  logic                  rready_1,
  output logic [data_width-1:0] rdata_1,
  output resp_e                 rresp_1,
  output logic                  rvalid_1,
  input  logic [addr_width-1:0] awaddr_1,
  input  logic                  awvalid_1,
  output logic                  awready_1,
  input  logic [data_width-1:0] wdata_1,
  input  logic [strb_width-1:0] wstrb_1,
  input  logic                  wvalid_1,
  output logic                  wready_1,
  input  logic                  bready_1,
  output resp_e                 bresp_1,
  output logic                  bvalid_1,
  output logic [addr_width-1:0] timer_araddr,
  output logic                  timer_arvalid,
  input  logic                  timer_arready,
  output logic                  timer_rready,
  input  logic [data_width-1:0] timer_rdata,
  input  resp_e                 timer_rresp,
  input  logic                  timer_rvalid,
  output logic                  ext_arvalid,
  input  logic                  ext_arready,
  output logic [id_width-1:0]   ext_arid,
  output logic [addr_width-1:0] ext_araddr,
  output logic [7:0]            ext_arlen,
  output logic [2:0]            ext_arsize,
  output logic [1:0]            ext_arburst,
  output logic                  ext_rready,
  input  logic                  ext_rvalid,
  input  logic [id_width-1:0]   ext_rid,
  input  logic [data_width-1:0] ext_rdata,
  input  logic [1:0]            ext_rresp,
  input  logic                  ext_rlast,
  output logic                  ext_awvalid,
  input  logic                  ext_awready,
  output logic [id_width-1:0]   ext_awid,
  output logic [addr_width-1:0] ext_awaddr,
  output logic [7:0]            ext_awlen,
  output logic [2:0]            ext_awsize,
  output logic [1:0]            ext_awburst,
  output logic                  ext_wvalid,
  input  logic                  ext_wready,
  output logic [data_width-1:0] ext_wdata,
  output logic [strb_width-1:0] ext_wstrb,
  output logic                  ext_wlast,
  output logic                  ext_bready,
  input  logic                  ext_bvalid,
  input  logic [id_width-1:0]   ext_bid,
  input  logic [1:0]            ext_bresp,
  output logic                  txn_done
);

  logic                  lsu_rd;    // lsu grant is a read.
  logic                  addr_done; // address phase already handshaken.
  logic                  sel_fetch, sel_lsu, to_timer, to_ext;
  logic                  rd_txn, wr_txn, rd_timer, rd_ext;
  logic [addr_width-1:0] req_araddr;
  logic                  req_arvalid, req_rready;
  logic                  r_ours, b_ours;
  logic                  rd_arready, rd_rvalid;
  logic [data_width-1:0] rd_rdata;
  resp_e                 rd_rresp;

  assign sel_fetch = (grant == grant_fetch);
  assign sel_lsu   = (grant == grant_lsu);
  assign to_timer  = (target == target_timer);
  assign to_ext    = (target == target_ext);
  assign rd_txn    = sel_fetch | (sel_lsu & lsu_rd);
  assign wr_txn    = sel_lsu & ~lsu_rd & to_ext;
  assign rd_timer  = rd_txn & to_timer;
  assign rd_ext    = rd_txn & to_ext;

  assign req_araddr  = sel_lsu ? araddr_1 : araddr_0;
  assign req_arvalid = rd_txn & ~addr_done & (sel_lsu ? arvalid_1 : arvalid_0);
  assign req_rready  = sel_lsu ? rready_1 : rready_0;

  // stray responses with a foreign id are drained, never forwarded.
  assign r_ours = ext_rlast & (ext_rid == ext_id);
  assign b_ours = (ext_bid == ext_id);

  assign timer_araddr  = rd_timer ? req_araddr : '0;
  assign timer_arvalid = to_timer & req_arvalid;
  assign timer_rready  = rd_timer & req_rready;

  assign ext_arvalid = to_ext & req_arvalid;
  assign ext_araddr  = rd_ext ? req_araddr : '0;
  assign ext_rready  = rd_ext & (r_ours ? req_rready : ext_rvalid);
  assign ext_arid    = ext_id;
  assign ext_arlen   = 8'd0; // single beat.
  assign ext_arsize  = ext_size_word;
  assign ext_arburst = ext_burst_incr;

  assign ext_awvalid = wr_txn & ~addr_done & awvalid_1;
  assign ext_awaddr  = wr_txn ? awaddr_1 : '0;
  assign ext_awid    = ext_id;
  assign ext_awlen   = 8'd0;
  assign ext_awsize  = ext_size_word;
  assign ext_awburst = ext_burst_incr;
  assign ext_wvalid  = wr_txn & wvalid_1;
  assign ext_wdata   = wr_txn ? wdata_1 : '0;
  assign ext_wstrb   = wr_txn ? wstrb_1 : '0;
  assign ext_wlast   = ext_wvalid;
  assign ext_bready  = wr_txn & bready_1;

  assign rd_arready = ~addr_done & (to_timer ? timer_arready : ext_arready);
  assign rd_rvalid  = to_timer ? timer_rvalid : (ext_rvalid & r_ours);
  assign rd_rdata   = to_timer ? timer_rdata : ext_rdata;
  assign rd_rresp   = to_timer ? timer_rresp : resp_e'(ext_rresp);

  assign arready_0 = sel_fetch & rd_txn & rd_arready;
  assign rvalid_0  = sel_fetch & rd_txn & rd_rvalid;
  assign rdata_0   = (sel_fetch & rd_txn) ? rd_rdata : '0;
  assign rresp_0   = (sel_fetch & rd_txn) ? rd_rresp : resp_okay;

  assign arready_1 = sel_lsu & rd_txn & rd_arready;
  assign rvalid_1  = sel_lsu & rd_txn & rd_rvalid;
  assign rdata_1   = (sel_lsu & rd_txn) ? rd_rdata : '0;
  assign rresp_1   = (sel_lsu & rd_txn) ? rd_rresp : resp_okay;

  assign awready_1 = wr_txn & ~addr_done & ext_awready;
  assign wready_1  = wr_txn & ext_wready;
  assign bvalid_1  = wr_txn & ext_bvalid & b_ours;
  assign bresp_1   = wr_txn ? resp_e'(ext_bresp) : resp_okay;

  assign txn_done = (rvalid_0 & rready_0) | (rvalid_1 & rready_1) | (bvalid_1 & bready_1);

  always_ff @(posedge clock) begin
    if (reset) begin
      lsu_rd    <= 1'b0;
      addr_done <= 1'b0;
    end else begin
      if (grant == grant_none) begin
        lsu_rd <= arvalid_1; // same choice the arbiter makes on this edge.
      end
      if (txn_done) begin
        addr_done <= 1'b0;
      end else if ((arready_0 & arvalid_0) | (arready_1 & arvalid_1) |
                   (awready_1 & awvalid_1)) begin
        addr_done <= 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- design/soc_map_pkg.sv
`default_nettype none

package soc_map_pkg;

  // low mtime word, the high word sits right above it.
  localparam logic [31:0] default_mtime_addr = 32'ha000_0048;

  localparam logic [3:0] default_ext_id = 4'd4;

  localparam logic [2:0] ext_size_word  = 3'd2; // 4 bytes per beat.
  localparam logic [1:0] ext_burst_incr = 2'b01;

endpackage

`default_nettype wire

//--- design/soc_mem_top.sv
`timescale 1ns/1ps
`default_nettype none

module soc_mem_top import bus_pkg::*, soc_map_pkg::*; #(
  parameter logic [addr_width-1:0] mtime_addr = default_mtime_addr,
  parameter logic [id_width-1:0]   ext_id     = default_ext_id
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [addr_width-1:0] araddr_0,
  input  logic                  arvalid_0,
  output logic                  arready_0,
  input  logic                  rready_0,
  output logic [data_width-1:0] rdata_0,
  output resp_e                 rresp_0,
  output logic                  rvalid_0,
  input  logic [addr_width-1:0] araddr_1,
  input  logic                  arvalid_1,
  output logic                  arready_1,
  input  logic                  rready_1,
  output logic [data_width-1:0] rdata_1,
  output resp_e                 rresp_1,
  output logic                  rvalid_1,
  input  logic [addr_width-1:0] awaddr_1,
  input  logic                  awvalid_1,
  output logic                  awready_1,
  input  logic [data_width-1:0] wdata_1,
  input  logic [strb_width-1:0] wstrb_1,
  input  logic                  wvalid_1,
  output logic                  wready_1,
  input  logic                  bready_1,
  output resp_e                 bresp_1,
  output logic                  bvalid_1,
  output logic                  ext_arvalid,
  input  logic                  ext_arready,
  output logic [id_width-1:0]   ext_arid,
  output logic [addr_width-1:0] ext_araddr,
  output logic [7:0]            ext_arlen,
  output logic [2:0]            ext_arsize,
  output logic [1:0]            ext_arburst,
  output logic                  ext_rready,
  input  logic                  ext_rvalid,
  input  logic [id_width-1:0]   ext_rid,
  input  logic [data_width-1:0] ext_rdata,
  input  logic [1:0]            ext_rresp,
  input  logic                  ext_rlast,
  output logic                  ext_awvalid,
  input  logic                  ext_awready,
  output logic [id_width-1:0]   ext_awid,
  output logic [addr_width-1:0] ext_awaddr,
  output logic [7:0]            ext_awlen,
  output logic [2:0]            ext_awsize,
  output logic [1:0]            ext_awburst,
  output logic                  ext_wvalid,
  input  logic                  ext_wready,
  output logic [data_width-1:0] ext_wdata,
  output logic [strb_width-1:0] ext_wstrb,
  output logic                  ext_wlast,
  output logic                  ext_bready,
  input  logic                  ext_bvalid,
  input  logic [id_width-1:0]   ext_bid,
  input  logic [1:0]            ext_bresp
);

  grant_e                grant;
  target_e               target;
  logic                  txn_done;
  logic [addr_width-1:0] timer_araddr;
  logic                  timer_arvalid, timer_arready, timer_rready, timer_rvalid;
  logic [data_width-1:0] timer_rdata;
  resp_e                 timer_rresp;

  mem_arbiter #(
    .mtime_addr(mtime_addr)
  ) mem_arbiter_i (
    .clock    (clock),
    .reset    (reset),
    .arvalid_0(arvalid_0),
    .araddr_0 (araddr_0),
    .arvalid_1(arvalid_1),
    .araddr_1 (araddr_1),
    .awvalid_1(awvalid_1),
    .txn_done (txn_done),
    .grant    (grant),
    .target   (target)
  );

  mem_router #(
    .ext_id(ext_id)
  ) mem_router_i (
    .clock(clock), .reset(reset), .grant(grant), .target(target),
    .araddr_0(araddr_0), .arvalid_0(arvalid_0), .arready_0(arready_0),
    .rready_0(rready_0), .rdata_0(rdata_0), .rresp_0(rresp_0), .rvalid_0(rvalid_0),
    .araddr_1(araddr_1), .arvalid_1(arvalid_1), .arready_1(arready_1),
    .rready_1(rready_1), .rdata_1(rdata_1), .rresp_1(rresp_1), .rvalid_1(rvalid_1),
    .awaddr_1(awaddr_1), .awvalid_1(awvalid_1), .awready_1(awready_1),
    .wdata_1(wdata_1), .wstrb_1(wstrb_1), .wvalid_1(wvalid_1), .wready_1(wready_1),
    .bready_1(bready_1), .bresp_1(bresp_1), .bvalid_1(bvalid_1),
    .timer_araddr(timer_araddr), .timer_arvalid(timer_arvalid),
    .timer_arready(timer_arready), .timer_rready(timer_rready),
    .timer_rdata(timer_rdata), .timer_rresp(timer_rresp), .timer_rvalid(timer_rvalid),
    .ext_arvalid(ext_arvalid), .ext_arready(ext_arready), .ext_arid(ext_arid),
    .ext_araddr(ext_araddr), .ext_arlen(ext_arlen), .ext_arsize(ext_arsize),
    .ext_arburst(ext_arburst), .ext_rready(ext_rready), .ext_rvalid(ext_rvalid),
    .ext_rid(ext_rid), .ext_rdata(ext_rdata), .ext_rresp(ext_rresp),
    .ext_rlast(ext_rlast), .ext_awvalid(ext_awvalid), .ext_awready(ext_awready),
    .ext_awid(ext_awid), .ext_awaddr(ext_awaddr), .ext_awlen(ext_awlen),
    .ext_awsize(ext_awsize), .ext_awburst(ext_awburst), .ext_wvalid(ext_wvalid),
    .ext_wready(ext_wready), .ext_wdata(ext_wdata), .ext_wstrb(ext_wstrb),
    .ext_wlast(ext_wlast), .ext_bready(ext_bready), .ext_bvalid(ext_bvalid),
    .ext_bid(ext_bid), .ext_bresp(ext_bresp),
    .txn_done(txn_done)
  );

  clint_timer #(
    .mtime_addr(mtime_addr)
  ) clint_timer_i (
    .clock  (clock),
    .reset  (reset),
    .araddr (timer_araddr),
    .arvalid(timer_arvalid),
    .arready(timer_arready),
    .rready (timer_rready),
    .rdata  (timer_rdata),
    .rresp  (timer_rresp),
    .rvalid (timer_rvalid)
  );

endmodule

`default_nettype wire

//--- soc_mem.f
design/bus_pkg.sv
design/soc_map_pkg.sv
design/mem_arbiter.sv
design/mem_router.sv
design/clint_timer.sv
design/soc_mem_top.sv
test/tb_soc_mem_chk.sv
test/tb_soc_mem.sv

//--- test/tb_soc_mem.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem import bus_pkg::*; ();

  localparam logic [31:0] mtime_base = 32'ha000_0048;
  localparam logic [3:0]  tb_ext_id  = 4'd4;
  localparam logic [31:0] err_base   = 32'h4000_0000; // slave answers slverr in this 256 byte window.
  localparam int          max_wait   = 200;

  logic clock, reset;
  logic [31:0] araddr_0, araddr_1, awaddr_1, wdata_1, rdata_0, rdata_1;
  logic arvalid_0, arready_0, rready_0, rvalid_0, arvalid_1, arready_1, rready_1, rvalid_1;
  logic awvalid_1, awready_1, wvalid_1, wready_1, bready_1, bvalid_1;
  logic [3:0] wstrb_1;
  resp_e rresp_0, rresp_1, bresp_1;
  logic ext_arvalid, ext_arready, ext_rready, ext_rvalid, ext_rlast, ext_awvalid, ext_awready;
  logic ext_wvalid, ext_wready, ext_wlast, ext_bready, ext_bvalid;
  logic [3:0] ext_arid, ext_rid, ext_awid, ext_bid, ext_wstrb;
  logic [31:0] ext_araddr, ext_rdata, ext_awaddr, ext_wdata;
  logic [7:0] ext_arlen, ext_awlen;
  logic [2:0] ext_arsize, ext_awsize;
  logic [1:0] ext_arburst, ext_awburst, ext_rresp, ext_bresp;

  logic [31:0] lfsr;
  logic [63:0] mtime_count;
  logic [31:0] shadow [logic [31:0]];
  logic [31:0] mem [logic [31:0]];
  logic        rd_busy, aw_got, w_got, r_hs, b_hs;
  logic [31:0] rd_addr, wr_addr, wr_data;
  logic [3:0]  wr_strb;
  int          checks, errors, timeouts, ar_count, exp_ar, aw_count, exp_aw, assert_fails;
  time         t_r0, t_ar1;

  soc_mem_top #(
    .mtime_addr(mtime_base),
    .ext_id    (tb_ext_id)
  ) soc_mem_top_i (.*);

  initial clock = 1'b0;
  always #2 clock = ~clock;

  always @(posedge clock) begin
    if (reset) begin
      mtime_count <= '0;
    end else begin
      mtime_count <= mtime_count + 64'd1;
    end
  end

  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = {1'b0, lfsr[31:1]} ^ (lfsr[0] ? 32'h8020_0003 : 32'h0);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  function automatic logic [31:0] fill_word(input logic [31:0] a);
    return {a[15:0], a[31:16]} ^ 32'h3c5a_a5c3;
  endfunction

  function automatic logic in_err(input logic [31:0] a);
    return a[31:8] == err_base[31:8];
  endfunction

  // expected word after merging the written bytes into the old contents.
  function automatic logic [31:0] merge_word(input logic [31:0] old, nw, input logic [3:0] strb);
    logic [31:0] w;
    w = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) w[8*b +: 8] = nw[8*b +: 8];
    end
    return w;
  endfunction

  function automatic logic [31:0] ref_read(input logic [31:0] a);
    return shadow.exists(a) ? shadow[a] : fill_word(a);
  endfunction

  task automatic check_data(input string name, input logic [data_width-1:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_resp(input string name, input resp_e got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic check_count(input string name, input logic [31:0] got, exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("Fail %s got %h expected %h", name, got, exp);
    end
  endtask

  task automatic note_timeout(input string what);
    timeouts++;
    $display("timeout: no handshake on %s within %0d cycles", what, max_wait);
  endtask

  // external slave, one read and one write in flight at most.
  always begin
    @(negedge clock);
    if (reset) begin
      ext_arready = 1'b0;
      ext_rvalid  = 1'b0;
      ext_awready = 1'b0;
      ext_wready  = 1'b0;
      ext_bvalid  = 1'b0;
      ext_rdata   = '0;
      ext_rresp   = '0;
      ext_bresp   = '0;
      rd_busy     = 1'b0;
      aw_got      = 1'b0;
      w_got       = 1'b0;
    end else begin
      if (r_hs) ext_rvalid = 1'b0;
      if (b_hs) ext_bvalid = 1'b0;
      if (rd_busy && !ext_rvalid) begin
        ext_rvalid = 1'b1;
        ext_rresp  = in_err(rd_addr) ? resp_slverr : resp_okay;
        ext_rdata  = in_err(rd_addr) ? 32'h0 :
                     (mem.exists(rd_addr) ? mem[rd_addr] : fill_word(rd_addr));
      end
      if (aw_got && w_got && !ext_bvalid) begin
        if (!in_err(wr_addr)) begin
          if (!mem.exists(wr_addr)) mem[wr_addr] = fill_word(wr_addr);
          for (int b = 0; b < 4; b++) begin
            if (wr_strb[b]) mem[wr_addr][8*b +: 8] = wr_data[8*b +: 8];
          end
        end
        ext_bvalid = 1'b1;
        ext_bresp  = in_err(wr_addr) ? resp_slverr : resp_okay;
        aw_got     = 1'b0;
        w_got      = 1'b0;
      end
      ext_arready = !rd_busy && (rand_bits(2) != 0);
      ext_awready = !aw_got && !ext_bvalid && (rand_bits(2) != 0);
      ext_wready  = !w_got && !ext_bvalid && (rand_bits(2) != 0);
    end
    #1; // decide the handshakes of the coming rising edge.
    r_hs = ext_rvalid && ext_rready;
    b_hs = ext_bvalid && ext_bready;
    if (r_hs) rd_busy = 1'b0;
    if (ext_arvalid && ext_arready) begin
      rd_busy = 1'b1;
      rd_addr = ext_araddr;
      ar_count++;
    end
    if (ext_awvalid && ext_awready) begin
      aw_got  = 1'b1;
      wr_addr = ext_awaddr;
      aw_count++;
    end
    if (ext_wvalid && ext_wready) begin
      w_got   = 1'b1;
      wr_data = ext_wdata;
      wr_strb = ext_wstrb;
      check_count("ext_wlast", ext_wlast, 1);
    end
  end

  task automatic do_read(input int port, input logic [31:0] addr, output time ar_t, r_t);
    logic [63:0] cnt;
    logic [31:0] data;
    resp_e       resp;
    logic        done;
    int          n;
    string       tag;
    tag  = $sformatf("_%0d", port);
    ar_t = 0;
    r_t  = 0;
    cnt  = '0;
    data = '0;
    resp = resp_okay;
    if (addr != mtime_base && addr != mtime_base + 32'd4) exp_ar++;
    @(negedge clock);
    if (port == 0) begin
      araddr_0  = addr;
      arvalid_0 = 1'b1;
    end else begin
      araddr_1  = addr;
      arvalid_1 = 1'b1;
    end
    done = 1'b0;
    n = 0;
    while (!done && n < max_wait) begin
      #1;
      done = (port == 0) ? arready_0 : arready_1;
      if (done) begin
        cnt  = mtime_count; // non-reset edges before the handshake edge.
        ar_t = $time;
      end
      @(negedge clock);
      n++;
    end
    if (port == 0) arvalid_0 = 1'b0;
    else arvalid_1 = 1'b0;
    if (!done) begin
      note_timeout({"arready", tag});
      return;
    end
    done = 1'b0;
    n = 0;
    while (!done && n < max_wait) begin
      if (port == 0) rready_0 = (rand_bits(2) != 0);
      else rready_1 = (rand_bits(2) != 0);
      #1;
      if (port == 0 ? (rvalid_0 && rready_0) : (rvalid_1 && rready_1)) begin
        done = 1'b1;
        data = (port == 0) ? rdata_0 : rdata_1;
        resp = (port == 0) ? rresp_0 : rresp_1;
        r_t  = $time;
      end
      @(negedge clock);
      n++;
    end
    if (port == 0) rready_0 = 1'b0;
    else rready_1 = 1'b0;
    if (!done) begin
      note_timeout({"rvalid", tag});
      return;
    end
    if (addr == mtime_base || addr == mtime_base + 32'd4) begin
      check_data({"rdata", tag}, data, (addr == mtime_base) ? cnt[31:0] : cnt[63:32]);
      check_resp({"rresp", tag}, resp, resp_okay);
    end else if (in_err(addr)) begin
      check_resp({"rresp", tag}, resp, resp_slverr);
    end else begin
      check_data({"rdata", tag}, data, ref_read(addr));
      check_resp({"rresp", tag}, resp, resp_okay);
    end
  endtask

  task automatic do_write(input logic [31:0] addr, data, input logic [3:0] strb, output time aw_t);
    resp_e resp;
    logic  aw_hs, w_hs, done;
    int    n;
    aw_t = 0;
    resp = resp_okay;
    exp_aw++;
    @(negedge clock);
    awaddr_1  = addr;
    awvalid_1 = 1'b1;
    wdata_1   = data;
    wstrb_1   = strb;
    wvalid_1  = 1'b1;
    n = 0;
    while ((awvalid_1 || wvalid_1) && n < max_wait) begin
      #1;
      aw_hs = awvalid_1 && awready_1;
      w_hs  = wvalid_1 && wready_1;
      if (aw_hs) aw_t = $time;
      @(negedge clock);
      if (aw_hs) awvalid_1 = 1'b0;
      if (w_hs) wvalid_1 = 1'b0;
      n++;
    end
    if (awvalid_1 || wvalid_1) begin
      awvalid_1 = 1'b0;
      wvalid_1  = 1'b0;
      note_timeout("awready_1 or wready_1");
      return;
    end
    done = 1'b0;
    n = 0;
    while (!done && n < max_wait) begin
      bready_1 = (rand_bits(2) != 0);
      #1;
      if (bvalid_1 && bready_1) begin
        done = 1'b1;
        resp = bresp_1;
      end
      @(negedge clock);
      n++;
    end
    bready_1 = 1'b0;
    if (!done) begin
      note_timeout("bvalid_1");
      return;
    end
    check_resp("bresp_1", resp, in_err(addr) ? resp_slverr : resp_okay);
    if (!in_err(addr)) shadow[addr] = merge_word(ref_read(addr), data, strb);
  endtask

  initial begin
    logic [31:0] addr;
    logic [1:0]  op;
    time         t_dummy;
    lfsr = 32'h1264_5c20;
    {checks, errors, timeouts, ar_count, exp_ar, aw_count, exp_aw, assert_fails} = '0;
    {r_hs, b_hs} = 2'b00;
    reset = 1'b1;
    {araddr_0, araddr_1, awaddr_1, wdata_1, wstrb_1} = '0;
    {arvalid_0, rready_0, arvalid_1, rready_1, awvalid_1, wvalid_1, bready_1} = '0;
    {ext_arready, ext_rvalid, ext_awready, ext_wready, ext_bvalid} = '0;
    {ext_rdata, ext_rresp, ext_bresp} = '0;
    ext_rid   = tb_ext_id;
    ext_bid   = tb_ext_id;
    ext_rlast = 1'b1;
    repeat (16) @(posedge clock);
    @(negedge clock);
    reset = 1'b0;

    @(negedge clock);
    #1;
    check_count("requester readies and valids",
                {arready_0, rvalid_0, arready_1, rvalid_1, awready_1, wready_1, bvalid_1}, 0);
    check_count("ext valids and readies",
                {ext_arvalid, ext_rready, ext_awvalid, ext_wvalid, ext_wlast, ext_bready}, 0);
    check_count("ext_arid", ext_arid, tb_ext_id);
    check_count("ext_awid", ext_awid, tb_ext_id);
    check_count("ext_arlen", ext_arlen, 0);
    check_count("ext_awlen", ext_awlen, 0);
    check_count("ext_arsize", ext_arsize, 2);
    check_count("ext_awsize", ext_awsize, 2);
    check_count("ext_arburst", ext_arburst, 1);
    check_count("ext_awburst", ext_awburst, 1);

    for (int i = 0; i < 4; i++) begin
      addr = 32'h0000_1000 + (rand_bits(6) << 2);
      do_write(addr, rand_bits(32), rand_bits(4), t_dummy);
      do_read(1, addr, t_dummy, t_dummy);
    end

    do_read(0, mtime_base, t_dummy, t_dummy);
    do_read(1, mtime_base + 32'd4, t_dummy, t_dummy);
    do_read(1, mtime_base, t_dummy, t_dummy);
    do_read(0, mtime_base + 32'd4, t_dummy, t_dummy);

    // same-cycle requests, fetch has priority.
    fork
      do_read(0, 32'h0000_2000 + (rand_bits(4) << 2), t_dummy, t_r0);
      do_read(1, 32'h0000_1000, t_ar1, t_dummy);
    join
    check_count("lsu read after fetch response", t_ar1 > t_r0, 1);
    fork
      do_read(0, 32'h0000_2040, t_dummy, t_r0);
      do_write(32'h0000_1004, rand_bits(32), 4'hf, t_ar1);
    join
    check_count("lsu write after fetch response", t_ar1 > t_r0, 1);

    for (int i = 0; i < 40; i++) begin
      op = rand_bits(2);
      if (rand_bits(3) == 0) addr = err_base + (rand_bits(4) << 2);
      else if (rand_bits(4) == 0) addr = mtime_base + (rand_bits(1) << 2);
      else addr = 32'h0000_1000 + (rand_bits(4) << 2);
      if (op == 2'd0) begin
        do_read(0, addr, t_dummy, t_dummy);
      end else if (op == 2'd1) begin
        do_read(1, addr, t_dummy, t_dummy);
      end else if (addr != mtime_base && addr != mtime_base + 32'd4) begin
        do_write(addr, rand_bits(32), rand_bits(4), t_dummy);
      end
    end

    repeat (4) @(negedge clock);
    check_count("ext read handshakes", ar_count, exp_ar);
    check_count("ext write handshakes", aw_count, exp_aw);
    assert_fails = soc_mem_top_i.mem_router_i.tb_soc_mem_chk_i.fails;
    $display("checks %0d, errors %0d, timeouts %0d, assertion failures %0d",
             checks, errors, timeouts, assert_fails);
    if (errors == 0 && timeouts == 0 && assert_fails == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- test/tb_soc_mem_chk.sv
`timescale 1ns/1ps
`default_nettype none

module tb_soc_mem_chk import bus_pkg::*; (
  input logic                  clock,
  input logic                  reset,
  input logic                  arready_0,
  input logic                  arready_1,
  input logic                  arvalid_0,
  input logic                  arvalid_1,
  input logic                  ext_arvalid,
  input logic                  ext_rvalid,
  input logic                  ext_rready,
  input logic [data_width-1:0] ext_rdata
);

  int fails = 0; // failed assertions so far.

  one_arready: assert property (@(posedge clock) disable iff (reset)
    !(arready_0 && arready_1))
    else begin
      $error("arready_0 and arready_1 high together");
      fails++;
    end

  ar_from_requester: assert property (@(posedge clock) disable iff (reset)
    ext_arvalid |-> (arvalid_0 || arvalid_1))
    else begin
      $error("ext_arvalid without a requester arvalid");
      fails++;
    end

  r_held: assert property (@(posedge clock) disable iff (reset)
    (ext_rvalid && !ext_rready) |=> (ext_rvalid && $stable(ext_rdata)))
    else begin
      $error("ext read response dropped or changed under back-pressure");
      fails++;
    end

endmodule

bind mem_router tb_soc_mem_chk tb_soc_mem_chk_i (.*);

`default_nettype wire
